// File: list.f
common/switch_pkg.sv
switch/ingress_buffer.sv
switch/mac_table.sv
switch/forward_engine.sv
hw/switch_regs.sv
hw/eth_switch.sv
verification/tb_clk.sv
verification/tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb -f list.f -o tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi

// File: verification/tb.sv
`timescale 1ns/1ns

module tb;

  import switch_pkg::*;

  localparam int DRIVE_DLY     = 2;
  localparam int RESET_CYCLES  = 5;
  localparam int QUIET_CYCLES  = 3000;
  localparam int DRAIN_TIMEOUT = 40000;
  localparam int APB_TIMEOUT   = 16;
  localparam int BURST         = 3;

  typedef logic [7:0] byte_q_t [$];

  // Frame as the model keeps it, payload comes from the tag
  typedef struct packed {
    mac_t             dst;
    logic [15:0]      tag;
    logic [LEN_W-1:0] len;
  } frame_t;

  logic               clk;
  logic               arst_n;
  phy_t [N_PORTS-1:0] rx_phy;
  phy_t [N_PORTS-1:0] tx_phy;
  logic [APB_AW-1:0]  paddr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [APB_DW-1:0]  pwdata;
  logic [APB_DW-1:0]  prdata;
  logic               pready;
  logic               pslverr;

  // Model state
  int          mac_tbl   [mac_t];
  frame_t      exp_q     [N_PORTS][N_PORTS][$];
  port_stats_t exp_stats [N_PORTS];
  phy_t        stream    [N_PORTS][$];
  logic [7:0]  got_q     [N_PORTS][$];
  int          gap_min = IFG_RESET;

  // Monitor state
  bit [N_PORTS-1:0] in_frm;
  bit [N_PORTS-1:0] had_frame;
  int               idle_run [N_PORTS];
  int               cycle;
  int               last_active;

  tb_clk tb_clk_i (
    .clk (clk)
  );

  eth_switch eth_switch_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .rx_phy  (rx_phy),
    .tx_phy  (tx_phy),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_frame(input string name, input byte_q_t got, input byte_q_t exp);
    if (got.size() != exp.size()) begin
      report_failure($sformatf("FAILED time=%0t %s length: got %0d expected %0d",
                               $time, name, got.size(), exp.size()));
    end
    foreach (exp[i]) begin
      if (got[i] !== exp[i]) begin
        report_failure($sformatf("FAILED time=%0t %s byte %0d: got %h expected %h",
                                 $time, name, i, got[i], exp[i]));
      end
    end
  endtask

  task automatic check_stats(input string name, input port_stats_t got,
                             input port_stats_t exp);
    if (got !== exp) begin
      report_failure($sformatf(
        "FAILED time=%0t %s: got rx=%0d drops=%0d tx=%0d expected rx=%0d drops=%0d tx=%0d",
        $time, name, got.rx_frames, got.drops, got.tx_frames,
        exp.rx_frames, exp.drops, exp.tx_frames));
    end
  endtask

  task automatic check_reg(input string name, input logic [APB_DW-1:0] got,
                           input logic got_err, input logic [APB_DW-1:0] exp,
                           input logic exp_err);
    if (got !== exp) begin
      report_failure($sformatf("FAILED time=%0t %s prdata: got %h expected %h",
                               $time, name, got, exp));
    end
    if (got_err !== exp_err) begin
      report_failure($sformatf("FAILED time=%0t %s pslverr: got %b expected %b",
                               $time, name, got_err, exp_err));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Frame building and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic mac_t port_mac(input int p);
    return 48'h0200_0000_1000 + mac_t'(p);
  endfunction

  function automatic logic [7:0] frame_byte(input int src, input frame_t f, input int i);
    mac_t s;
    s = port_mac(src);
    if (i < 6) begin
      return f.dst[47-8*i -: 8];
    end else if (i < 12) begin
      return s[47-8*(i-6) -: 8];
    end
    return 8'(f.tag + 16'(i * 29)) ^ f.tag[15:8];
  endfunction

  function automatic void build_frame(input int src, input frame_t f, output byte_q_t q);
    q = {};
    for (int i = 0; i < int'(f.len); i++) begin
      q.push_back(frame_byte(src, f, i));
    end
  endfunction

  function automatic frame_t rand_frame();
    frame_t f;
    int     pick;
    pick  = int'($urandom_range(4, 0));
    f.len = LEN_W'($urandom_range(200, MIN_FRAME));
    f.tag = 16'($urandom);
    if (pick < N_PORTS) begin
      f.dst = port_mac(pick);
    end else if (pick == N_PORTS) begin
      f.dst = MAC_BROADCAST;
    end else begin
      // Never seen as a source
      f.dst = 48'h0200_0000_2000 + mac_t'($urandom_range(255, 0));
    end
    return f;
  endfunction

  function automatic void model_frame(input int src, input frame_t f);
    port_mask_t m;
    if (int'(f.len) < MIN_FRAME) begin
      exp_stats[src].drops = exp_stats[src].drops + 16'd1;
      return;
    end
    exp_stats[src].rx_frames = exp_stats[src].rx_frames + 16'd1;
    for (int o = 0; o < N_PORTS; o++) begin
      m[o] = (o != src);
    end
    if (f.dst != MAC_BROADCAST && mac_tbl.exists(f.dst)) begin
      m = '0;
      if (mac_tbl[f.dst] != src) begin
        m[mac_tbl[f.dst]] = 1'b1;
      end
    end
    // Source learned after the lookup
    mac_tbl[port_mac(src)] = src;
    for (int o = 0; o < N_PORTS; o++) begin
      if (m[o]) begin
        exp_q[o][src].push_back(f);
        exp_stats[o].tx_frames = exp_stats[o].tx_frames + 16'd1;
      end
    end
  endfunction

  function automatic int frames_pending();
    int n;
    n = 0;
    for (int o = 0; o < N_PORTS; o++) begin
      for (int s = 0; s < N_PORTS; s++) begin
        n = n + exp_q[o][s].size();
      end
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic tick();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic queue_frame(input int p, input frame_t f);
    byte_q_t q;
    phy_t    ph;
    model_frame(p, f);
    build_frame(p, f, q);
    foreach (q[i]) begin
      ph.dat = q[i];
      ph.val = 1'b1;
      stream[p].push_back(ph);
    end
    // One idle cycle closes the frame
    ph = '0;
    stream[p].push_back(ph);
  endtask

  task automatic drive_streams();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      tick();
      busy = 1'b0;
      for (int p = 0; p < N_PORTS; p++) begin
        if (stream[p].size() > 0) begin
          rx_phy[p] = stream[p].pop_front();
          busy      = 1'b1;
        end else begin
          rx_phy[p] = '0;
        end
      end
    end
  endtask

  // Done once every expected frame arrived and the outputs stayed quiet
  task automatic wait_drain();
    int start;
    int since;
    int cyc;
    start = cycle;
    cyc   = 0;
    since = start;
    while (frames_pending() != 0 || cycle - since < QUIET_CYCLES) begin
      @(posedge clk);
      cyc   = cyc + 1;
      since = (last_active > start) ? last_active : start;
      if (cyc > DRAIN_TIMEOUT) begin
        report_failure($sformatf("Timed out with %0d expected frames still missing",
                                 frames_pending()));
      end
    end
  endtask

  task automatic send_rounds(input int rounds);
    for (int r = 0; r < rounds; r++) begin
      for (int k = 0; k < BURST; k++) begin
        for (int p = 0; p < N_PORTS; p++) begin
          queue_frame(p, rand_frame());
        end
      end
      drive_streams();
      wait_drain();
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] wdata,
                          output logic [APB_DW-1:0] rdata, output logic err);
    int cyc;
    tick();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    tick();
    penable = 1'b1;
    cyc     = 0;
    @(negedge clk);
    while (!pready) begin
      cyc = cyc + 1;
      if (cyc > APB_TIMEOUT) begin
        report_failure($sformatf("APB access to 0x%02h never saw pready", addr));
      end
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    logic [APB_DW-1:0] rdata;
    logic              err;
    apb_xfer(1'b1, addr, data, rdata, err);
    if (err) begin
      report_failure($sformatf("APB write to 0x%02h raised pslverr", addr));
    end
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                          output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic read_port_stats(input int p);
    port_stats_t       got;
    logic [APB_DW-1:0] rdata [3];
    logic              err;
    logic [APB_AW-1:0] base;
    base = APB_AW'(REG_STAT0) + APB_AW'(16 * p);
    for (int i = 0; i < 3; i++) begin
      apb_read(base + APB_AW'(4 * i), rdata[i], err);
      if (err) begin
        report_failure($sformatf("Reading counter 0x%02h raised pslverr", base + 4 * i));
      end
    end
    got.rx_frames = rdata[0][STAT_W-1:0];
    got.drops     = rdata[1][STAT_W-1:0];
    got.tx_frames = rdata[2][STAT_W-1:0];
    check_stats($sformatf("STAT%0d", p), got, exp_stats[p]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic finish_frame(input int p);
    byte_q_t got;
    byte_q_t exp;
    frame_t  f;
    mac_t    src;
    int      s;
    got = got_q[p];
    got_q[p].delete();
    if (got.size() < 12) begin
      report_failure($sformatf("Frame of %0d bytes on tx_phy[%0d] is too short for a header",
                               got.size(), p));
    end
    src = {got[6], got[7], got[8], got[9], got[10], got[11]};
    s   = -1;
    for (int i = 0; i < N_PORTS; i++) begin
      if (src == port_mac(i)) begin
        s = i;
      end
    end
    if (s < 0) begin
      report_failure($sformatf("Frame on tx_phy[%0d] has unknown source %h", p, src));
    end
    if (exp_q[p][s].size() == 0) begin
      report_failure($sformatf("Unexpected frame from port %0d on tx_phy[%0d]", s, p));
    end
    f = exp_q[p][s].pop_front();
    build_frame(s, f, exp);
    check_frame($sformatf("tx_phy[%0d] frame from port %0d", p, s), got, exp);
  endtask

  // Sampled on the falling edge, away from the DUT updates
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (arst_n) begin
      for (int p = 0; p < N_PORTS; p++) begin
        if (tx_phy[p].val) begin
          last_active = cycle;
          if (!in_frm[p] && had_frame[p] && idle_run[p] < gap_min) begin
            report_failure($sformatf(
              "FAILED time=%0t idle cycles on tx_phy[%0d]: got %0d expected at least %0d",
              $time, p, idle_run[p], gap_min));
          end
          in_frm[p] = 1'b1;
          got_q[p].push_back(tx_phy[p].dat);
        end else if (in_frm[p]) begin
          finish_frame(p);
          in_frm[p]    = 1'b0;
          had_frame[p] = 1'b1;
          idle_run[p]  = 1;
        end else begin
          idle_run[p] = idle_run[p] + 1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [APB_DW-1:0] rdata;
    logic              err;
    frame_t            f;
    int                gap_val;
    void'($urandom(96));
    rx_phy  = '0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    arst_n  = 1'b0;
    for (int p = 0; p < N_PORTS; p++) begin
      exp_stats[p] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;

    apb_read(REG_IFG, rdata, err);
    check_reg("REG_IFG after reset", rdata, err, APB_DW'(IFG_RESET), 1'b0);

    // Broadcast from each port in turn, every source gets learned
    for (int p = 0; p < N_PORTS; p++) begin
      f     = rand_frame();
      f.dst = MAC_BROADCAST;
      queue_frame(p, f);
      drive_streams();
      wait_drain();
    end

    // Mixed unicast, broadcast and unknown traffic on all ports
    send_rounds(4);

    // Runts between good frames
    for (int p = 0; p < N_PORTS; p++) begin
      f     = rand_frame();
      f.len = LEN_W'($urandom_range(MIN_FRAME - 1, 1));
      queue_frame(p, f);
      queue_frame(p, rand_frame());
    end
    drive_streams();
    wait_drain();
    for (int p = 0; p < N_PORTS; p++) begin
      read_port_stats(p);
    end

    // New gap, the monitor checks every idle run against it
    gap_val = int'($urandom_range(40, 4));
    apb_write(REG_IFG, APB_DW'(gap_val));
    gap_min = gap_val;
    apb_read(REG_IFG, rdata, err);
    check_reg("REG_IFG", rdata, err, APB_DW'(gap_val), 1'b0);
    send_rounds(2);

    // Flush, then known addresses flood until relearned
    apb_write(REG_CTRL, 32'h1);
    mac_tbl.delete();
    for (int i = 0; i < 4; i++) begin
      f     = rand_frame();
      f.dst = port_mac((i + 1) % N_PORTS);
      queue_frame(i % N_PORTS, f);
      drive_streams();
      wait_drain();
    end

    for (int p = 0; p < N_PORTS; p++) begin
      read_port_stats(p);
    end
    apb_read(8'h0C, rdata, err);
    check_reg("unknown address 0x0C", rdata, err, '0, 1'b1);
    apb_read(8'h1C, rdata, err);
    check_reg("unknown address 0x1C", rdata, err, '0, 1'b1);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: verification/tb_clk.sv
`timescale 1ns/1ns

module tb_clk #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

// File: hw/eth_switch.sv
`timescale 1ns/1ns

module eth_switch (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  switch_pkg::phy_t [switch_pkg::N_PORTS-1:0]  rx_phy,
  output switch_pkg::phy_t [switch_pkg::N_PORTS-1:0]  tx_phy,
  input  logic [switch_pkg::APB_AW-1:0]               paddr,
  input  logic                                        psel,
  input  logic                                        penable,
  input  logic                                        pwrite,
  input  logic [switch_pkg::APB_DW-1:0]               pwdata,
  output logic [switch_pkg::APB_DW-1:0]               prdata,
  output logic                                        pready,
  output logic                                        pslverr
);

  import switch_pkg::*;

  frame_desc_t [N_PORTS-1:0] desc;
  port_mask_t                desc_valid;
  port_mask_t                desc_pop;
  port_mask_t                rd_en;
  logic [N_PORTS-1:0][7:0]   rd_data;
  port_mask_t                rx_frame;
  port_mask_t                drop;
  port_mask_t                tx_frame;
  port_mask_t                dst_mask;
  mac_t                      lookup_mac;
  mac_t                      learn_mac;
  logic [PORT_W-1:0]         src_port;
  logic [PORT_W-1:0]         learn_port;
  logic                      learn;
  logic                      flush;
  logic [7:0]                ifg;

  ////////////////////////////////////////////////////////////////////////////
  // One frame store per port
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < N_PORTS; p++) begin : g_ingress
    ingress_buffer ingress_buffer_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .rx         (rx_phy[p]),
      .desc       (desc[p]),
      .desc_valid (desc_valid[p]),
      .desc_pop   (desc_pop[p]),
      .rd_en      (rd_en[p]),
      .rd_data    (rd_data[p]),
      .rx_frame   (rx_frame[p]),
      .drop       (drop[p])
    );
  end

  mac_table mac_table_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .lookup_mac (lookup_mac),
    .src_port   (src_port),
    .dst_mask   (dst_mask),
    .learn      (learn),
    .learn_mac  (learn_mac),
    .learn_port (learn_port)
  );

  forward_engine forward_engine_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .desc       (desc),
    .desc_valid (desc_valid),
    .desc_pop   (desc_pop),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .ifg        (ifg),
    .lookup_mac (lookup_mac),
    .src_port   (src_port),
    .dst_mask   (dst_mask),
    .learn      (learn),
    .learn_mac  (learn_mac),
    .learn_port (learn_port),
    .tx         (tx_phy),
    .tx_frame   (tx_frame)
  );

  // Config and counters
  switch_regs switch_regs_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .ifg      (ifg),
    .flush    (flush),
    .rx_frame (rx_frame),
    .drop     (drop),
    .tx_frame (tx_frame)
  );

endmodule

// File: hw/switch_regs.sv
`timescale 1ns/1ns

module switch_regs (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [switch_pkg::APB_AW-1:0]     paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [switch_pkg::APB_DW-1:0]     pwdata,
  output logic [switch_pkg::APB_DW-1:0]     prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic [7:0]                        ifg,
  output logic                              flush,
  input  switch_pkg::port_mask_t            rx_frame,
  input  switch_pkg::port_mask_t            drop,
  input  switch_pkg::port_mask_t            tx_frame
);

  import switch_pkg::*;

  port_stats_t       stats [N_PORTS];
  logic              access;
  logic              wr_access;
  logic              known;
  logic              stat_sel;
  logic [PORT_W-1:0] stat_idx;
  reg_addr_e         base;

  function automatic logic [STAT_W-1:0] sat_inc(input logic [STAT_W-1:0] v,
                                                input logic en);
    return (en && v != '1) ? v + 1'b1 : v;
  endfunction

  assign access    = psel && penable;
  assign wr_access = access && pwrite;
  assign pready    = 1'b1;
  assign pslverr   = access && !known;
  assign base      = reg_addr_e'({paddr[APB_AW-1:4], 4'h0});

  always_comb begin
    stat_sel = 1'b1;
    stat_idx = '0;
    case (base)
      REG_STAT0: stat_idx = PORT_W'(0);
      REG_STAT1: stat_idx = PORT_W'(1);
      REG_STAT2: stat_idx = PORT_W'(2);
      default:   stat_sel = 1'b0;
    endcase
  end

  // Read mux, valid in the access cycle
  always_comb begin
    prdata = '0;
    known  = 1'b1;
    if (paddr == REG_IFG) begin
      prdata = APB_DW'(ifg);
    end else if (paddr == REG_CTRL) begin
      prdata = '0;
    end else if (stat_sel) begin
      case (paddr[3:0])
        4'h0:    prdata = APB_DW'(stats[stat_idx].rx_frames);
        4'h4:    prdata = APB_DW'(stats[stat_idx].drops);
        4'h8:    prdata = APB_DW'(stats[stat_idx].tx_frames);
        default: known  = 1'b0;
      endcase
    end else begin
      known = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ifg   <= 8'(IFG_RESET);
      flush <= 1'b0;
      for (int p = 0; p < N_PORTS; p++) begin
        stats[p] <= '0;
      end
    end else begin
      // CTRL bit 0 self-clears, one pulse per write
      flush <= wr_access && (paddr == REG_CTRL) && pwdata[0];
      if (wr_access && paddr == REG_IFG) begin
        ifg <= pwdata[7:0];
      end
      for (int p = 0; p < N_PORTS; p++) begin
        stats[p].rx_frames <= sat_inc(stats[p].rx_frames, rx_frame[p]);
        stats[p].drops     <= sat_inc(stats[p].drops, drop[p]);
        stats[p].tx_frames <= sat_inc(stats[p].tx_frames, tx_frame[p]);
      end
    end
  end

endmodule

// File: switch/forward_engine.sv
`timescale 1ns/1ns

module forward_engine (
  input  logic                                             clk,
  input  logic                                             arst_n,
  input  switch_pkg::frame_desc_t [switch_pkg::N_PORTS-1:0] desc,
  input  switch_pkg::port_mask_t                           desc_valid,
  output switch_pkg::port_mask_t                           desc_pop,
  output switch_pkg::port_mask_t                           rd_en,
  input  logic [switch_pkg::N_PORTS-1:0][7:0]              rd_data,
  input  logic [7:0]                                       ifg,
  output switch_pkg::mac_t                                 lookup_mac,
  output logic [switch_pkg::PORT_W-1:0]                    src_port,
  input  switch_pkg::port_mask_t                           dst_mask,
  output logic                                             learn,
  output switch_pkg::mac_t                                 learn_mac,
  output logic [switch_pkg::PORT_W-1:0]                    learn_port,
  output switch_pkg::phy_t [switch_pkg::N_PORTS-1:0]       tx,
  output switch_pkg::port_mask_t                           tx_frame
);

  import switch_pkg::*;

  engine_state_e     state;
  logic [PORT_W-1:0] rr_ptr;
  logic [PORT_W-1:0] pick;
  logic              found;
  frame_desc_t       cur;
  port_mask_t        mask;
  logic [LEN_W-1:0]  byte_cnt;
  logic [7:0]        gap_cnt;
  logic              rd_issue;
  logic              rd_vld_q;
  logic              last_byte;

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin port pick
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    int idx;
    found = 1'b0;
    pick  = rr_ptr;
    // Search starts one past the port served last
    for (int i = 1; i <= N_PORTS; i++) begin
      idx = int'(rr_ptr) + i;
      if (idx >= N_PORTS) begin
        idx = idx - N_PORTS;
      end
      if (!found && desc_valid[idx]) begin
        found = 1'b1;
        pick  = PORT_W'(idx);
      end
    end
  end

  assign desc_pop = (state == IDLE && found) ? port_mask_t'(1) << pick : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Table access and byte stream
  ////////////////////////////////////////////////////////////////////////////

  assign lookup_mac = cur.dst;
  assign src_port   = rr_ptr;
  assign learn      = (state == LOOKUP);
  assign learn_mac  = cur.src;
  assign learn_port = rr_ptr;

  assign rd_issue  = (state == STREAM) && (byte_cnt < cur.len);
  assign last_byte = (state == STREAM) && (byte_cnt == cur.len);
  assign rd_en     = rd_issue ? port_mask_t'(1) << rr_ptr : '0;
  assign tx_frame  = last_byte ? mask : '0;

  // A zero mask drains the frame without any output
  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      tx[p].val = rd_vld_q && mask[p];
      tx[p].dat = (rd_vld_q && mask[p]) ? rd_data[rr_ptr] : 8'h00;
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && found) begin
      cur <= desc[pick];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      rr_ptr   <= '0;
      mask     <= '0;
      byte_cnt <= '0;
      gap_cnt  <= '0;
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_issue;
      case (state)
        IDLE: begin
          if (found) begin
            rr_ptr <= pick;
            state  <= LOOKUP;
          end
        end
        LOOKUP: begin
          mask     <= dst_mask;
          byte_cnt <= '0;
          state    <= STREAM;
        end
        STREAM: begin
          if (rd_issue) begin
            byte_cnt <= byte_cnt + 1'b1;
          end
          if (last_byte) begin
            if (mask == '0 || ifg == 8'd0) begin
              state <= IDLE;
            end else begin
              gap_cnt <= ifg;
              state   <= GAP;
            end
          end
        end
        GAP: begin
          if (gap_cnt <= 8'd1) begin
            state <= IDLE;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: switch/mac_table.sv
`timescale 1ns/1ns

module mac_table (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          flush,
  input  switch_pkg::mac_t              lookup_mac,
  input  logic [switch_pkg::PORT_W-1:0] src_port,
  output switch_pkg::port_mask_t        dst_mask,
  input  logic                          learn,
  input  switch_pkg::mac_t              learn_mac,
  input  logic [switch_pkg::PORT_W-1:0] learn_port
);

  import switch_pkg::*;

  logic [TABLE_SIZE-1:0] ent_valid;
  mac_t                  ent_mac  [TABLE_SIZE];
  logic [PORT_W-1:0]     ent_port [TABLE_SIZE];
  logic [TABLE_AW-1:0]   fill_ptr;
  logic                  look_hit;
  logic [PORT_W-1:0]     look_port;
  logic                  learn_hit;
  logic [TABLE_AW-1:0]   learn_idx;
  logic                  do_learn;
  port_mask_t            flood_mask;

  // Group addresses never get learned as a source
  assign do_learn = learn && !learn_mac[40] && !flush;

  always_comb begin
    look_hit  = 1'b0;
    look_port = '0;
    learn_hit = 1'b0;
    learn_idx = fill_ptr;
    for (int i = 0; i < TABLE_SIZE; i++) begin
      if (ent_valid[i] && ent_mac[i] == lookup_mac) begin
        look_hit  = 1'b1;
        look_port = ent_port[i];
      end
      if (ent_valid[i] && ent_mac[i] == learn_mac) begin
        learn_hit = 1'b1;
        learn_idx = TABLE_AW'(i);
      end
    end
  end

  assign flood_mask = ~(port_mask_t'(1) << src_port);

  always_comb begin
    if (lookup_mac == MAC_BROADCAST || !look_hit) begin
      dst_mask = flood_mask;
    end else if (look_port == src_port) begin
      // Destination sits behind the source port, filter it
      dst_mask = '0;
    end else begin
      dst_mask = port_mask_t'(1) << look_port;
    end
  end

  always_ff @(posedge clk) begin
    if (do_learn) begin
      ent_mac[learn_idx]  <= learn_mac;
      ent_port[learn_idx] <= learn_port;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ent_valid <= '0;
      fill_ptr  <= '0;
    end else if (flush) begin
      ent_valid <= '0;
      fill_ptr  <= '0;
    end else if (do_learn) begin
      ent_valid[learn_idx] <= 1'b1;
      // New addresses take slots in turn, oldest slot gets reused
      if (!learn_hit) begin
        fill_ptr <= fill_ptr + 1'b1;
      end
    end
  end

endmodule

// File: switch/ingress_buffer.sv
`timescale 1ns/1ns

module ingress_buffer (
  input  logic                    clk,
  input  logic                    arst_n,
  input  switch_pkg::phy_t        rx,
  output switch_pkg::frame_desc_t desc,
  output logic                    desc_valid,
  input  logic                    desc_pop,
  input  logic                    rd_en,
  output logic [7:0]              rd_data,
  output logic                    rx_frame,
  output logic                    drop
);

  import switch_pkg::*;

  logic [7:0]  ram [BUF_DEPTH];
  frame_desc_t dq  [DESC_DEPTH];

  // One extra pointer bit tells a full buffer from an empty one
  logic [BUF_AW:0]        commit_ptr;
  logic [BUF_AW:0]        rd_ptr;
  logic [BUF_AW:0]        wr_cnt;
  logic [BUF_AW:0]        space;
  logic [BUF_AW-1:0]      wr_addr;
  logic [DESC_AW:0]       dq_wr;
  logic [DESC_AW:0]       dq_rd;
  logic [8*HDR_BYTES-1:0] hdr;
  logic                   in_frame;
  logic                   ovf;
  logic                   no_room;
  logic                   wr_en;
  logic                   frame_end;
  logic                   dq_full;
  logic                   bad_frame;

  assign space     = (BUF_AW+1)'(BUF_DEPTH) - (commit_ptr - rd_ptr);
  assign no_room   = (wr_cnt == space) || (wr_cnt == (BUF_AW+1)'(MAX_FRAME));
  assign wr_en     = rx.val && !ovf && !no_room;
  assign wr_addr   = commit_ptr[BUF_AW-1:0] + wr_cnt[BUF_AW-1:0];
  assign frame_end = in_frame && !rx.val;
  assign dq_full   = (dq_wr - dq_rd) == (DESC_AW+1)'(DESC_DEPTH);
  assign bad_frame = ovf || dq_full || (wr_cnt < (BUF_AW+1)'(MIN_FRAME));

  assign desc       = dq[dq_rd[DESC_AW-1:0]];
  assign desc_valid = (dq_wr != dq_rd);

  // Byte RAM, read data lands one cycle after rd_en
  always_ff @(posedge clk) begin
    if (wr_en) begin
      ram[wr_addr] <= rx.dat;
    end
    if (rd_en) begin
      rd_data <= ram[rd_ptr[BUF_AW-1:0]];
    end
  end

  // Bytes 0..11 shift in, dst ends up on top
  always_ff @(posedge clk) begin
    if (wr_en && wr_cnt < (BUF_AW+1)'(HDR_BYTES)) begin
      hdr <= {hdr[8*HDR_BYTES-9:0], rx.dat};
    end
  end

  always_ff @(posedge clk) begin
    if (frame_end && !bad_frame) begin
      dq[dq_wr[DESC_AW-1:0]] <= '{dst: hdr[8*HDR_BYTES-1 -: 48],
                                  src: hdr[47:0],
                                  len: wr_cnt[LEN_W-1:0]};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      commit_ptr <= '0;
      rd_ptr     <= '0;
      wr_cnt     <= '0;
      dq_wr      <= '0;
      dq_rd      <= '0;
      in_frame   <= 1'b0;
      ovf        <= 1'b0;
      rx_frame   <= 1'b0;
      drop       <= 1'b0;
    end else begin
      rx_frame <= 1'b0;
      drop     <= 1'b0;
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (desc_pop) begin
        dq_rd <= dq_rd + 1'b1;
      end
      if (rx.val) begin
        in_frame <= 1'b1;
        if (wr_en) begin
          wr_cnt <= wr_cnt + 1'b1;
        end else begin
          ovf <= 1'b1;
        end
      end else if (frame_end) begin
        in_frame <= 1'b0;
        ovf      <= 1'b0;
        wr_cnt   <= '0;
        // Dropping just leaves commit_ptr where the frame began
        if (bad_frame) begin
          drop <= 1'b1;
        end else begin
          commit_ptr <= commit_ptr + wr_cnt;
          dq_wr      <= dq_wr + 1'b1;
          rx_frame   <= 1'b1;
        end
      end
    end
  end

endmodule

// File: common/switch_pkg.sv
package switch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int N_PORTS    = 3;
  localparam int BUF_DEPTH  = 2048;
  localparam int DESC_DEPTH = 4;
  localparam int TABLE_SIZE = 8;
  localparam int MIN_FRAME  = 14;
  localparam int IFG_RESET  = 10;

  localparam int PORT_W    = $clog2(N_PORTS);
  localparam int BUF_AW    = $clog2(BUF_DEPTH);
  localparam int DESC_AW   = $clog2(DESC_DEPTH);
  localparam int TABLE_AW  = $clog2(TABLE_SIZE);
  localparam int LEN_W     = 11;
  localparam int MAX_FRAME = 2**LEN_W - 1;
  localparam int HDR_BYTES = 12;
  localparam int STAT_W    = 16;

  // APB bus widths
  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [47:0]        mac_t;
  typedef logic [N_PORTS-1:0] port_mask_t;

  localparam mac_t MAC_BROADCAST = 48'hffff_ffff_ffff;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
  } phy_t;

  typedef struct packed {
    mac_t             dst;
    mac_t             src;
    logic [LEN_W-1:0] len;
  } frame_desc_t;

  typedef struct packed {
    logic [STAT_W-1:0] rx_frames;
    logic [STAT_W-1:0] drops;
    logic [STAT_W-1:0] tx_frames;
  } port_stats_t;

  typedef enum logic [1:0] {IDLE, LOOKUP, STREAM, GAP} engine_state_e;

  // Counter blocks hold rx_frames at +0, drops at +4, tx_frames at +8
  typedef enum logic [APB_AW-1:0] {
    REG_IFG   = 8'h00,
    REG_CTRL  = 8'h04,
    REG_STAT0 = 8'h10,
    REG_STAT1 = 8'h20,
    REG_STAT2 = 8'h30
  } reg_addr_e;

endpackage
